// ==== verif/pipe_patterns.txt ====
# P <byte address hex> <instruction hex>, text after a lone # is a note
# R <test> <register, decimal> <expected hex>; M <test> <byte address hex> <expected word hex>
P 000 20010005 # addi $1, $0, 5
P 004 2002fffd # addi $2, $0, -3
P 008 00221820 # add  $3, $1, $2
P 00c 00612022 # sub  $4, $3, $1
P 010 00812824 # and  $5, $4, $1
P 014 00a33025 # or   $6, $5, $3
P 018 0083382a # slt  $7, $4, $3
P 01c 20e80064 # addi $8, $7, 100
P 020 20090040 # addi $9, $0, 0x40
P 024 ad260000 # sw   $6, 0($9)
P 028 8d2a0000 # lw   $10, 0($9)
P 02c 01485820 # add  $11, $10, $8
P 030 200c0007 # addi $12, $0, 7
P 034 11860001 # beq  $12, $6, +1 (taken)
P 038 200d0001 # addi $13, $0, 1 (skipped)
P 03c 11800001 # beq  $12, $0, +1 (not taken)
P 040 200e0009 # addi $14, $0, 9
P 044 200f0080 # addi $15, $0, 0x80
P 048 a1e20000 # sb   $2, 0($15)
P 04c a1e80001 # sb   $8, 1($15)
P 050 a1eb0002 # sb   $11, 2($15)
P 054 a1e70003 # sb   $7, 3($15)
P 058 91f00000 # lbu  $16, 0($15)
P 05c 91f10001 # lbu  $17, 1($15)
P 060 91f20002 # lbu  $18, 2($15)
P 064 91f30003 # lbu  $19, 3($15)
P 068 fc000000 # halt
R alu_forward 1 00000005
R alu_forward 2 fffffffd
R alu_forward 3 00000002
R alu_forward 4 fffffffd
R alu_forward 5 00000005
R alu_forward 6 00000007
R alu_forward 7 00000001
R alu_forward 8 00000065
R load_use 10 00000007
R load_use 11 0000006c
M load_use 040 00000007
R branch 12 00000007
R branch 13 00000000
R branch 14 00000009
R byte_access 16 000000fd
R byte_access 17 00000065
R byte_access 18 0000006c
R byte_access 19 00000001
M byte_access 080 016c65fd

// ==== pipe.f ====
+incdir+include
source/mipsIsaPkg.sv
source/hazardPkg.sv
source/controlUnit.sv
source/registerFile.sv
source/hazardUnit.sv
source/aluExec.sv
source/instrMemory.sv
source/dataMemory.sv
source/pipe.sv
verif/pipeTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module pipeTb \
	-f pipe.f -o pipeSim
simOut=$(./obj_dir/pipeSim)
echo "$simOut"
if echo "$simOut" | grep -qx "No errors"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== verif/pipeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module pipeTb;

	localparam int HALT_TIMEOUT = 2000;
	localparam int FREEZE_TIMEOUT = 200;
	localparam int FREEZE_CYCLES = 5;
	localparam int HOLD_CYCLES = 10;
	localparam int MAX_TOKENS = 1000;
	// Halt marker in the primary opcode field
	localparam logic [5:0] HALT_OPCODE = 6'h3f;
	// Freeze once fetch is past the ALU block
	localparam logic [`PC_W-1:0] FREEZE_PC = `PC_W'(32);

	logic clk;
	logic rstN;
	logic run;
	logic imemWe;
	logic [$clog2(`IMEM_WORDS)-1:0] imemAddr;
	logic [`DATA_W-1:0] imemData;
	logic [4:0] dbgRegAddr;
	logic memSel;
	logic [`DMEM_AW-1:0] memAddr;
	logic [`PC_W-1:0] pc;
	logic [`DATA_W-1:0] dbgRegData;
	logic [`DATA_W-1:0] memData;
	logic halted;

	// Program image and expected values from the pattern file
	logic [`PC_W-1:0] progAddr [$];
	logic [`DATA_W-1:0] progWord [$];
	logic [7:0] chkKind [$];
	string chkName [$];
	logic [`DATA_W-1:0] chkAddr [$];
	logic [`DATA_W-1:0] chkVal [$];
	string testNames [$];

	// Bookkeeping
	int errCount;
	int testFails;
	int testsRun;
	int testsFailed;
	logic timedOut;
	logic fileError;

	pipe i_dut (
		.clk(clk), .rstN_i(rstN), .run_i(run), .imemWe_i(imemWe), .imemAddr_i(imemAddr),
		.imemData_i(imemData), .dbgRegAddr_i(dbgRegAddr), .memSel_i(memSel),
		.memAddr_i(memAddr), .pc_o(pc), .dbgRegData_o(dbgRegData), .memData_o(memData),
		.halted_o(halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------

	// Drive and sample point just past the edge
	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic checkValue(input string name, input string what,
		input logic [`DATA_W-1:0] expVal, input logic [`DATA_W-1:0] actVal);
		assert (actVal === expVal)
		else
		begin
			$display("[FAIL] %0s %0s: expected 0x%08h, actual 0x%08h", name, what, expVal,
				actVal);
			testFails++;
			errCount++;
		end
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (testFails != 0)
			testsFailed++;
		$display("[TEST] %0s done, %0d check(s) failed", name, testFails);
	endtask

	function automatic logic hasName(input string name);
		foreach (testNames[t])
		begin
			if (testNames[t] == name)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// Byte address of the first halt word in the program image
	function automatic logic [`PC_W-1:0] haltAddress();
		foreach (progWord[i])
		begin
			if (progWord[i][31:26] == HALT_OPCODE)
				return progAddr[i];
		end
		return '0;
	endfunction

	// Lines tagged P, R or M
	// Text after a lone # is skipped
	task automatic readPatterns();
		int fd;
		int nTok;
		int regNum;
		int guard;
		logic [7:0] tag;
		logic [8*16-1:0] nameBits;
		logic [8*128-1:0] rest;
		logic [`DATA_W-1:0] addr;
		logic [`DATA_W-1:0] value;
		string nameStr;
		fd = $fopen("verif/pipe_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the pattern file verif/pipe_patterns.txt");
			fileError = 1'b1;
		end
		else
		begin
			guard = 0;
			while (!$feof(fd) && guard < MAX_TOKENS)
			begin
				guard++;
				tag = '0;
				nTok = $fscanf(fd, "%s", tag);
				if (nTok == 1)
				begin
					if (tag == "#")
						nTok = $fgets(rest, fd);
					else if (tag == "P")
					begin
						nTok = $fscanf(fd, "%h %h", addr, value);
						progAddr.push_back(addr[`PC_W-1:0]);
						progWord.push_back(value);
					end
					else if (tag == "R" || tag == "M")
					begin
						nameBits = '0;
						// Register number in decimal and byte address in hex
						if (tag == "R")
						begin
							nTok = $fscanf(fd, "%s %d %h", nameBits, regNum, value);
							addr = 32'(regNum);
						end
						else
							nTok = $fscanf(fd, "%s %h %h", nameBits, addr, value);
						nameStr = string'(nameBits);
						chkKind.push_back(tag);
						chkName.push_back(nameStr);
						chkAddr.push_back(addr);
						chkVal.push_back(value);
						if (!hasName(nameStr))
							testNames.push_back(nameStr);
					end
					else
					begin
						$display("Unknown line tag %0s in the pattern file", tag);
						fileError = 1'b1;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One word per clock while run is low
	task automatic loadProgram();
		imemWe = 1'b1;
		for (int i = 0; i < progWord.size(); i++)
		begin
			imemAddr = progAddr[i][`PC_W-1:2];
			imemData = progWord[i];
			stepCycle();
		end
		imemWe = 1'b0;
	endtask

	// ------------------------------
	// Tests
	// ------------------------------

	// Drop run mid-program and expect a still PC
	task automatic freezeTest();
		logic reached;
		logic [`PC_W-1:0] frozenPc;
		testFails = 0;
		reached = 1'b0;
		for (int c = 0; c < FREEZE_TIMEOUT && !reached; c++)
		begin
			stepCycle();
			reached = (pc >= FREEZE_PC);
		end
		if (!reached)
		begin
			$display("Timeout: pc_o did not reach the freeze point within %0d cycles",
				FREEZE_TIMEOUT);
			timedOut = 1'b1;
		end
		else
		begin
			frozenPc = pc;
			run = 1'b0;
			for (int c = 0; c < FREEZE_CYCLES; c++)
			begin
				stepCycle();
				checkValue("freeze", "pc_o", 32'(frozenPc), 32'(pc));
			end
			run = 1'b1;
			finishTest("freeze");
		end
	endtask

	// Wait for halt and expect PC and flag to hold
	task automatic haltTest();
		logic seen;
		logic [`PC_W-1:0] expPc;
		testFails = 0;
		seen = 1'b0;
		// Fetch stops one word past the halt once decode holds it
		expPc = haltAddress() + `PC_W'(4);
		for (int c = 0; c < HALT_TIMEOUT && !seen; c++)
		begin
			stepCycle();
			seen = halted;
		end
		if (!seen)
		begin
			$display("Timeout: halted_o did not rise within %0d cycles", HALT_TIMEOUT);
			timedOut = 1'b1;
		end
		else
		begin
			checkValue("halt", "pc_o", 32'(expPc), 32'(pc));
			for (int c = 0; c < HOLD_CYCLES; c++)
			begin
				stepCycle();
				checkValue("halt", "pc_o", 32'(expPc), 32'(pc));
				assert (halted === 1'b1)
				else
				begin
					$display("halt: halted_o fell again after it had risen");
					testFails++;
					errCount++;
				end
			end
			finishTest("halt");
		end
	endtask

	// Registers through the debug port and words through the memory mux
	task automatic runDataTest(input string name);
		testFails = 0;
		for (int i = 0; i < chkName.size(); i++)
		begin
			if (chkName[i] == name)
			begin
				if (chkKind[i] == "R")
				begin
					dbgRegAddr = chkAddr[i][4:0];
					stepCycle();
					checkValue(name, $sformatf("r%0d", chkAddr[i]), chkVal[i], dbgRegData);
				end
				else
				begin
					memSel = 1'b1;
					memAddr = chkAddr[i][`DMEM_AW-1:0];
					stepCycle();
					checkValue(name, $sformatf("mem[0x%03h]", chkAddr[i][`DMEM_AW-1:0]),
						chkVal[i], memData);
					memSel = 1'b0;
				end
			end
		end
		finishTest(name);
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------

	initial
	begin
		rstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		dbgRegAddr = '0;
		memSel = 1'b0;
		memAddr = '0;
		errCount = 0;
		testFails = 0;
		testsRun = 0;
		testsFailed = 0;
		timedOut = 1'b0;
		fileError = 1'b0;

		readPatterns();
		repeat (3) stepCycle();
		rstN = 1'b1;

		if (!fileError)
		begin
			loadProgram();
			run = 1'b1;
			freezeTest();
		end
		if (!fileError && !timedOut)
			haltTest();
		// Pipeline drained and frozen by now
		if (!fileError && !timedOut)
		begin
			foreach (testNames[t])
				runDataTest(testNames[t]);
		end

		$display("Summary: %0d tests run, %0d passed, %0d failed, %0d failing checks",
			testsRun, testsRun - testsFailed, testsFailed, errCount);
		if (errCount == 0 && !timedOut && !fileError)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module pipe
(
	input wire logic clk,
	input wire logic rstN_i,
	input wire logic run_i,
	input wire logic imemWe_i,
	input wire logic [$clog2(`IMEM_WORDS)-1:0] imemAddr_i,
	input wire logic [`DATA_W-1:0] imemData_i,
	input wire logic [4:0] dbgRegAddr_i,
	input wire logic memSel_i,
	input wire logic [`DMEM_AW-1:0] memAddr_i,
	output logic [`PC_W-1:0] pc_o,
	output logic [`DATA_W-1:0] dbgRegData_o,
	output logic [`DATA_W-1:0] memData_o,
	output logic halted_o
);

	// Fetch
	logic [`PC_W-1:0] pcF;
	logic [`PC_W-1:0] pcPlus4F;
	logic [`PC_W-1:0] pcNext;
	logic [`DATA_W-1:0] instrF;
	logic haltSeen;
	logic haltF;
	// Decode
	logic [`DATA_W-1:0] instrD;
	logic [`PC_W-1:0] pcPlus4D;
	logic regWriteD;
	logic memToRegD;
	logic aluSrcD;
	logic regDstD;
	logic branchD;
	logic finalD;
	mipsIsaPkg::aluOpT aluOpD;
	mipsIsaPkg::memSizeT memReadD;
	mipsIsaPkg::memSizeT memWriteD;
	logic [`DATA_W-1:0] rd1D;
	logic [`DATA_W-1:0] rd2D;
	logic [`DATA_W-1:0] signImmD;
	logic [`DATA_W-1:0] cmpAD;
	logic [`DATA_W-1:0] cmpBD;
	logic pcSrcD;
	logic [`PC_W-1:0] pcBranchD;
	// Execute
	logic regWriteE;
	logic memToRegE;
	logic aluSrcE;
	logic regDstE;
	logic finalE;
	mipsIsaPkg::aluOpT aluOpE;
	mipsIsaPkg::memSizeT memReadE;
	mipsIsaPkg::memSizeT memWriteE;
	logic [`DATA_W-1:0] rd1E;
	logic [`DATA_W-1:0] rd2E;
	logic [4:0] rsE;
	logic [4:0] rtE;
	logic [4:0] rdE;
	logic [`DATA_W-1:0] signImmE;
	logic [`DATA_W-1:0] srcAE;
	logic [`DATA_W-1:0] srcBE;
	logic [`DATA_W-1:0] writeDataE;
	logic [`DATA_W-1:0] aluOutE;
	logic [4:0] writeRegE;
	// Memory
	logic regWriteM;
	logic memToRegM;
	logic finalM;
	mipsIsaPkg::memSizeT memReadM;
	mipsIsaPkg::memSizeT memWriteM;
	logic [`DATA_W-1:0] aluOutM;
	logic [`DATA_W-1:0] writeDataM;
	logic [4:0] writeRegM;
	logic [`DATA_W-1:0] readDataM;
	// Write-back
	logic regWriteW;
	logic memToRegW;
	logic finalW;
	logic [`DATA_W-1:0] readDataW;
	logic [`DATA_W-1:0] aluOutW;
	logic [4:0] writeRegW;
	logic [`DATA_W-1:0] resultW;
	// Hazard unit
	logic stallF;
	logic stallD;
	logic flushE;
	hazardPkg::fwdSelT fwdAD;
	hazardPkg::fwdSelT fwdBD;
	hazardPkg::fwdSelT fwdAE;
	hazardPkg::fwdSelT fwdBE;

	function automatic logic [`DATA_W-1:0] fwdMux
	(
		input hazardPkg::fwdSelT sel,
		input logic [`DATA_W-1:0] regVal,
		input logic [`DATA_W-1:0] wbVal,
		input logic [`DATA_W-1:0] memVal
	);
		case (sel)
			hazardPkg::FWD_MEM: return memVal;
			hazardPkg::FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// ------------------------------
	// Fetch
	// ------------------------------

	// Halt in decode freezes fetch from then on
	assign haltF = finalD || haltSeen;
	assign pcPlus4F = pcF + `PC_W'(4);
	assign pcNext = pcSrcD ? pcBranchD : pcPlus4F;
	assign pc_o = pcF;

	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			pcF <= '0;
			haltSeen <= 1'b0;
		end
		else if (run_i)
		begin
			if (!stallF && !haltF)
				pcF <= pcNext;
			if (finalD)
				haltSeen <= 1'b1;
		end
	end

	// Program load only while stopped
	instrMemory i_instrMemory (.clk(clk), .we_i(imemWe_i && !run_i), .wAddr_i(imemAddr_i),
		.wData_i(imemData_i), .pc_i(pcF), .instr_o(instrF));

	// F/D latch, cleared on taken beq or halt
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
			instrD <= '0;
		else if (run_i && !stallD)
			instrD <= (pcSrcD || haltF) ? '0 : instrF;
	end

	always_ff @(posedge clk)
	begin
		if (run_i && !stallD)
			pcPlus4D <= pcPlus4F;
	end

	// ------------------------------
	// Decode
	// ------------------------------

	controlUnit i_controlUnit (.opcode_i(instrD[31:26]), .funct_i(instrD[5:0]),
		.regWrite_o(regWriteD), .memToReg_o(memToRegD), .aluSrc_o(aluSrcD),
		.regDst_o(regDstD), .branch_o(branchD), .final_o(finalD), .aluOp_o(aluOpD),
		.memRead_o(memReadD), .memWrite_o(memWriteD));

	registerFile i_registerFile (.clk(clk), .rstN_i(rstN_i), .we_i(regWriteW), .run_i(run_i),
		.a1_i(instrD[25:21]), .a2_i(instrD[20:16]), .a3_i(writeRegW),
		.dbgAddr_i(dbgRegAddr_i), .wd_i(resultW), .rd1_o(rd1D), .rd2_o(rd2D),
		.dbgData_o(dbgRegData_o));

	assign signImmD = {{(`DATA_W-16){instrD[15]}}, instrD[15:0]};
	// Word offset scaled to bytes
	assign pcBranchD = pcPlus4D + {signImmD[`PC_W-3:0], 2'b00};

	// beq compare, operands possibly from MEM
	assign cmpAD = fwdMux(fwdAD, rd1D, resultW, aluOutM);
	assign cmpBD = fwdMux(fwdBD, rd2D, resultW, aluOutM);
	// no redirect while stalled, operands may be stale
	assign pcSrcD = branchD && (cmpAD == cmpBD) && !stallD;

	// D/E latch, flush injects a bubble
	always_ff @(posedge clk)
	begin
		if (!rstN_i || (run_i && flushE))
		begin
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			finalE <= 1'b0;
			memReadE <= mipsIsaPkg::MEM_NONE;
			memWriteE <= mipsIsaPkg::MEM_NONE;
		end
		else if (run_i)
		begin
			regWriteE <= regWriteD;
			memToRegE <= memToRegD;
			finalE <= finalD;
			memReadE <= memReadD;
			memWriteE <= memWriteD;
		end
	end

	always_ff @(posedge clk)
	begin
		if (run_i)
		begin
			aluSrcE <= aluSrcD;
			regDstE <= regDstD;
			aluOpE <= aluOpD;
			rd1E <= rd1D;
			rd2E <= rd2D;
			rsE <= instrD[25:21];
			rtE <= instrD[20:16];
			rdE <= instrD[15:11];
			signImmE <= signImmD;
		end
	end

	// ------------------------------
	// Execute
	// ------------------------------

	assign writeRegE = regDstE ? rdE : rtE;
	assign srcAE = fwdMux(fwdAE, rd1E, resultW, aluOutM);
	assign writeDataE = fwdMux(fwdBE, rd2E, resultW, aluOutM);
	assign srcBE = aluSrcE ? signImmE : writeDataE;

	aluExec i_aluExec (.srcA_i(srcAE), .srcB_i(srcBE), .aluOp_i(aluOpE), .result_o(aluOutE));

	// E/M latch
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			finalM <= 1'b0;
			memReadM <= mipsIsaPkg::MEM_NONE;
			memWriteM <= mipsIsaPkg::MEM_NONE;
		end
		else if (run_i)
		begin
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			finalM <= finalE;
			memReadM <= memReadE;
			memWriteM <= memWriteE;
		end
	end

	always_ff @(posedge clk)
	begin
		if (run_i)
		begin
			aluOutM <= aluOutE;
			writeDataM <= writeDataE;
			writeRegM <= writeRegE;
		end
	end

	// ------------------------------
	// Memory and write-back
	// ------------------------------

	dataMemory i_dataMemory (.clk(clk), .run_i(run_i), .memWrite_i(memWriteM),
		.memRead_i(memReadM), .aluAddr_i(aluOutM[`DMEM_AW-1:0]), .wData_i(writeDataM),
		.extSel_i(memSel_i), .extAddr_i(memAddr_i), .readData_o(readDataM),
		.extData_o(memData_o));

	// M/W latch plus sticky halt flag
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
			finalW <= 1'b0;
			halted_o <= 1'b0;
		end
		else if (run_i)
		begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
			finalW <= finalM;
			if (finalW)
				halted_o <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (run_i)
		begin
			readDataW <= readDataM;
			aluOutW <= aluOutM;
			writeRegW <= writeRegM;
		end
	end

	assign resultW = memToRegW ? readDataW : aluOutW;

	hazardUnit i_hazardUnit (.rsD_i(instrD[25:21]), .rtD_i(instrD[20:16]), .rsE_i(rsE),
		.rtE_i(rtE), .writeRegE_i(writeRegE), .writeRegM_i(writeRegM),
		.writeRegW_i(writeRegW), .branchD_i(branchD), .memToRegE_i(memToRegE),
		.regWriteE_i(regWriteE), .memToRegM_i(memToRegM), .regWriteM_i(regWriteM),
		.regWriteW_i(regWriteW), .stallF_o(stallF), .stallD_o(stallD), .flushE_o(flushE),
		.fwdAD_o(fwdAD), .fwdBD_o(fwdBD), .fwdAE_o(fwdAE), .fwdBE_o(fwdBE));

endmodule

`default_nettype wire

// ==== source/dataMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module dataMemory
(
	input wire logic clk,
	input wire logic run_i,
	input wire mipsIsaPkg::memSizeT memWrite_i,
	input wire mipsIsaPkg::memSizeT memRead_i,
	input wire logic [`DMEM_AW-1:0] aluAddr_i,
	input wire logic [`DATA_W-1:0] wData_i,
	input wire logic extSel_i,
	input wire logic [`DMEM_AW-1:0] extAddr_i,
	output logic [`DATA_W-1:0] readData_o,
	output logic [`DATA_W-1:0] extData_o
);

	logic [`DATA_W-1:0] mem [`DMEM_WORDS];
	logic [`DMEM_AW-1:0] addr;
	logic [`DMEM_AW-3:0] wordIdx;
	logic [1:0] laneSel;
	logic [3:0] byteEn;
	logic [`DATA_W-1:0] laneData;
	logic [`DATA_W-1:0] rawWord;

	// Outside address takes the single port when selected
	assign addr = extSel_i ? extAddr_i : aluAddr_i;
	assign wordIdx = addr[`DMEM_AW-1:2];
	assign laneSel = addr[1:0];

	// Byte enables per access size
	always_comb
	begin
		case (memWrite_i)
			mipsIsaPkg::MEM_WORD: byteEn = 4'b1111;
			mipsIsaPkg::MEM_BYTE: byteEn = 4'b0001 << laneSel;
			default: byteEn = 4'b0000;
		endcase
	end

	// Store byte replicated so every lane carries it
	assign laneData = (memWrite_i == mipsIsaPkg::MEM_BYTE) ? {4{wData_i[7:0]}} : wData_i;

	always_ff @(posedge clk)
	begin
		if (run_i)
		begin
			for (int lane = 0; lane < 4; lane++)
			begin
				if (byteEn[lane])
					mem[wordIdx][lane*8 +: 8] <= laneData[lane*8 +: 8];
			end
		end
	end

	assign rawWord = mem[wordIdx];
	assign extData_o = rawWord;

	// Load mask, lbu zero-extends the addressed lane
	always_comb
	begin
		case (memRead_i)
			mipsIsaPkg::MEM_BYTE:
				readData_o = {{(`DATA_W-8){1'b0}}, rawWord[{laneSel, 3'b000} +: 8]};
			default: readData_o = rawWord;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/instrMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module instrMemory
(
	input wire logic clk,
	input wire logic we_i,
	input wire logic [$clog2(`IMEM_WORDS)-1:0] wAddr_i,
	input wire logic [`DATA_W-1:0] wData_i,
	input wire logic [`PC_W-1:0] pc_i,
	output logic [`DATA_W-1:0] instr_o
);

	logic [`DATA_W-1:0] mem [`IMEM_WORDS];
	logic [`PC_W-3:0] wordIdx;

	// Load port, one word per clock
	always_ff @(posedge clk)
	begin
		if (we_i)
			mem[wAddr_i] <= wData_i;
	end

	// Word bits of the byte PC
	assign wordIdx = pc_i[`PC_W-1:2];

	// Past the end reads zero, which decodes as a no-op
	assign instr_o = (int'(wordIdx) < `IMEM_WORDS) ? mem[wordIdx] : '0;

endmodule

`default_nettype wire

// ==== source/aluExec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module aluExec
(
	input wire logic [`DATA_W-1:0] srcA_i,
	input wire logic [`DATA_W-1:0] srcB_i,
	input wire mipsIsaPkg::aluOpT aluOp_i,
	output logic [`DATA_W-1:0] result_o
);

	logic lessThan;

	// Signed compare for slt
	assign lessThan = $signed(srcA_i) < $signed(srcB_i);

	always_comb
	begin
		case (aluOp_i)
			mipsIsaPkg::ALU_SUB: result_o = srcA_i - srcB_i;
			mipsIsaPkg::ALU_AND: result_o = srcA_i & srcB_i;
			mipsIsaPkg::ALU_OR: result_o = srcA_i | srcB_i;
			mipsIsaPkg::ALU_SLT: result_o = {{(`DATA_W-1){1'b0}}, lessThan};
			// add, also address calc for loads and stores
			default: result_o = srcA_i + srcB_i;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
(
	input wire logic [4:0] rsD_i,
	input wire logic [4:0] rtD_i,
	input wire logic [4:0] rsE_i,
	input wire logic [4:0] rtE_i,
	input wire logic [4:0] writeRegE_i,
	input wire logic [4:0] writeRegM_i,
	input wire logic [4:0] writeRegW_i,
	input wire logic branchD_i,
	input wire logic memToRegE_i,
	input wire logic regWriteE_i,
	input wire logic memToRegM_i,
	input wire logic regWriteM_i,
	input wire logic regWriteW_i,
	output logic stallF_o,
	output logic stallD_o,
	output logic flushE_o,
	output hazardPkg::fwdSelT fwdAD_o,
	output hazardPkg::fwdSelT fwdBD_o,
	output hazardPkg::fwdSelT fwdAE_o,
	output hazardPkg::fwdSelT fwdBE_o
);

	logic lwStall;
	logic branchStall;

	// Memory stage wins over write-back, $0 never forwarded
	function automatic hazardPkg::fwdSelT fwdPick
	(
		input logic [4:0] src,
		input logic [4:0] regM,
		input logic wrM,
		input logic [4:0] regW,
		input logic wrW
	);
		if ((src != 5'd0) && (src == regM) && wrM)
			return hazardPkg::FWD_MEM;
		else if ((src != 5'd0) && (src == regW) && wrW)
			return hazardPkg::FWD_WB;
		else
			return hazardPkg::FWD_REG;
	endfunction

	// Execute operands
	assign fwdAE_o = fwdPick(rsE_i, writeRegM_i, regWriteM_i, writeRegW_i, regWriteW_i);
	assign fwdBE_o = fwdPick(rtE_i, writeRegM_i, regWriteM_i, writeRegW_i, regWriteW_i);

	// Branch compare in decode, write-back already covered by write-through
	assign fwdAD_o = fwdPick(rsD_i, writeRegM_i, regWriteM_i, writeRegW_i, 1'b0);
	assign fwdBD_o = fwdPick(rtD_i, writeRegM_i, regWriteM_i, writeRegW_i, 1'b0);

	// Load in execute feeding the instruction in decode
	assign lwStall = memToRegE_i && (writeRegE_i != 5'd0) &&
		((writeRegE_i == rsD_i) || (writeRegE_i == rtD_i));

	// beq operand not ready yet: ALU result in EX, or load data still in MEM
	assign branchStall = branchD_i &&
		((regWriteE_i && (writeRegE_i != 5'd0) &&
			((writeRegE_i == rsD_i) || (writeRegE_i == rtD_i))) ||
		(memToRegM_i && (writeRegM_i != 5'd0) &&
			((writeRegM_i == rsD_i) || (writeRegM_i == rtD_i))));

	// Hold F and D, send a bubble into EX
	assign stallF_o = lwStall || branchStall;
	assign stallD_o = lwStall || branchStall;
	assign flushE_o = lwStall || branchStall;

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module registerFile
(
	input wire logic clk,
	input wire logic rstN_i,
	input wire logic we_i,
	input wire logic run_i,
	input wire logic [4:0] a1_i,
	input wire logic [4:0] a2_i,
	input wire logic [4:0] a3_i,
	input wire logic [4:0] dbgAddr_i,
	input wire logic [`DATA_W-1:0] wd_i,
	output logic [`DATA_W-1:0] rd1_o,
	output logic [`DATA_W-1:0] rd2_o,
	output logic [`DATA_W-1:0] dbgData_o
);

	logic [`DATA_W-1:0] regs [32];
	logic wrActive;

	// Write from write-back, frozen while run is low; $0 never written
	assign wrActive = we_i && run_i && (a3_i != 5'd0);

	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			for (int r = 0; r < 32; r++)
				regs[r] <= '0;
		end
		else if (wrActive)
			regs[a3_i] <= wd_i;
	end

	// Write-through, decode sees the word retiring this cycle
	assign rd1_o = (a1_i == 5'd0) ? '0 :
		(wrActive && (a3_i == a1_i)) ? wd_i : regs[a1_i];
	assign rd2_o = (a2_i == 5'd0) ? '0 :
		(wrActive && (a3_i == a2_i)) ? wd_i : regs[a2_i];

	// Debug view, plain array read
	assign dbgData_o = (dbgAddr_i == 5'd0) ? '0 : regs[dbgAddr_i];

endmodule

`default_nettype wire

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit
(
	input wire logic [5:0] opcode_i,
	input wire logic [5:0] funct_i,
	output logic regWrite_o,
	output logic memToReg_o,
	output logic aluSrc_o,
	output logic regDst_o,
	output logic branch_o,
	output logic final_o,
	output mipsIsaPkg::aluOpT aluOp_o,
	output mipsIsaPkg::memSizeT memRead_o,
	output mipsIsaPkg::memSizeT memWrite_o
);

	always_comb
	begin
		// Bubble unless a known code says otherwise
		regWrite_o = 1'b0;
		memToReg_o = 1'b0;
		aluSrc_o = 1'b0;
		regDst_o = 1'b0;
		branch_o = 1'b0;
		final_o = 1'b0;
		aluOp_o = mipsIsaPkg::ALU_ADD;
		memRead_o = mipsIsaPkg::MEM_NONE;
		memWrite_o = mipsIsaPkg::MEM_NONE;

		case (opcode_i)
			mipsIsaPkg::OP_RTYPE:
			begin
				// Unknown funct (incl. the all-zero word) stays a bubble
				regDst_o = 1'b1;
				regWrite_o = 1'b1;
				case (funct_i)
					mipsIsaPkg::FN_ADD: aluOp_o = mipsIsaPkg::ALU_ADD;
					mipsIsaPkg::FN_SUB: aluOp_o = mipsIsaPkg::ALU_SUB;
					mipsIsaPkg::FN_AND: aluOp_o = mipsIsaPkg::ALU_AND;
					mipsIsaPkg::FN_OR: aluOp_o = mipsIsaPkg::ALU_OR;
					mipsIsaPkg::FN_SLT: aluOp_o = mipsIsaPkg::ALU_SLT;
					default: regWrite_o = 1'b0;
				endcase
			end
			mipsIsaPkg::OP_ADDI:
			begin
				regWrite_o = 1'b1;
				aluSrc_o = 1'b1;
			end
			// Loads, address is rs + imm
			mipsIsaPkg::OP_LW, mipsIsaPkg::OP_LBU:
			begin
				regWrite_o = 1'b1;
				aluSrc_o = 1'b1;
				memToReg_o = 1'b1;
				memRead_o = (opcode_i == mipsIsaPkg::OP_LW) ?
					mipsIsaPkg::MEM_WORD : mipsIsaPkg::MEM_BYTE;
			end
			// Stores, data comes from rt
			mipsIsaPkg::OP_SW, mipsIsaPkg::OP_SB:
			begin
				aluSrc_o = 1'b1;
				memWrite_o = (opcode_i == mipsIsaPkg::OP_SW) ?
					mipsIsaPkg::MEM_WORD : mipsIsaPkg::MEM_BYTE;
			end
			mipsIsaPkg::OP_BEQ: branch_o = 1'b1;
			mipsIsaPkg::OP_HALT: final_o = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/hazardPkg.sv ====
`default_nettype none

package hazardPkg;

	// Operand source select for the forwarding muxes
	// Decode only ever sees FWD_REG or FWD_MEM
	typedef enum logic [1:0]
	{
		FWD_REG = 2'd0,
		FWD_WB  = 2'd1,
		FWD_MEM = 2'd2
	} fwdSelT;

endpackage

`default_nettype wire

// ==== source/mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

	// Primary opcodes, instruction bits 31:26
	typedef enum logic [5:0]
	{
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_LBU   = 6'h24,
		OP_SB    = 6'h28,
		OP_SW    = 6'h2b,
		// Halt marker, rides down the pipe to write-back
		OP_HALT  = 6'h3f
	} opcodeT;

	// R-type function field, bits 5:0
	typedef enum logic [5:0]
	{
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} functT;

	// Execute-stage ALU operations
	typedef enum logic [2:0]
	{
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} aluOpT;

	// Access size, drives byte enables and read mask
	typedef enum logic [1:0]
	{
		MEM_NONE = 2'd0,
		MEM_WORD = 2'd1,
		MEM_BYTE = 2'd2
	} memSizeT;

endpackage

`default_nettype wire

// ==== include/pipe_defines.svh ====
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// Fetch PC width, byte addressed
`define PC_W 9

// Instruction store depth in words
`define IMEM_WORDS 128

// Data store byte address width and word depth
`define DMEM_AW 12
`define DMEM_WORDS 1024

// Datapath word width
`define DATA_W 32

`endif
